// ==== Makefile ====
SIM  := obj_dir/Vtb_ahb_mem_subsys
SRCS := $(shell cat tb.f)

.PHONY: run clean

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'PASS: all tests'

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -f tb.f --top-module tb_ahb_mem_subsys

clean:
	rm -rf obj_dir

// ==== boot_rom.hex ====
// Boot ROM image, one 64-bit doubleword per line, word 0 first
// Columns: tag b007c0de, 16-bit byte address, complement of that address
b007c0de0000ffff
b007c0de0008fff7
b007c0de0010ffef
b007c0de0018ffe7
b007c0de0020ffdf
b007c0de0028ffd7
b007c0de0030ffcf
b007c0de0038ffc7
b007c0de0040ffbf
b007c0de0048ffb7
b007c0de0050ffaf
b007c0de0058ffa7
b007c0de0060ff9f
b007c0de0068ff97
b007c0de0070ff8f
b007c0de0078ff87
b007c0de0080ff7f
b007c0de0088ff77
b007c0de0090ff6f
b007c0de0098ff67
b007c0de00a0ff5f
b007c0de00a8ff57
b007c0de00b0ff4f
b007c0de00b8ff47
b007c0de00c0ff3f
b007c0de00c8ff37
b007c0de00d0ff2f
b007c0de00d8ff27
b007c0de00e0ff1f
b007c0de00e8ff17
b007c0de00f0ff0f
b007c0de00f8ff07

// ==== design/ahb_mem_pkg.sv ====
/*
 * Boot memory subsystem shared definitions
 * Bus widths, memory map, memory depths and the enumerated
 * transfer, response and error-sequence codes
 */
`default_nettype none

package ahb_mem_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    localparam int AHB_DATA_WIDTH   = 64;
    localparam int AHB_ADDR_WIDTH   = 32;
    localparam int BYTE_OFFSET_BITS = 3;
    localparam int BYTE_LANES       = AHB_DATA_WIDTH / 8;

    //////////////////////////////////////////////////
    // Memory map
    // ROM is 32 doublewords, 256 bytes
    localparam logic [AHB_ADDR_WIDTH-1:0] ROM_BASE = 32'h0000_0000;
    localparam int ROM_DEPTH_WORDS = 32;
    localparam int ROM_ADDR_WIDTH  = 5;
    localparam int ROM_BYTE_BITS   = ROM_ADDR_WIDTH + BYTE_OFFSET_BITS;
    // Scratch SRAM is 512 doublewords, 4 KiB
    localparam logic [AHB_ADDR_WIDTH-1:0] SRAM_BASE = 32'h1000_0000;
    localparam int SRAM_DEPTH_WORDS = 512;
    localparam int SRAM_ADDR_WIDTH  = 9;
    localparam int SRAM_BYTE_BITS   = SRAM_ADDR_WIDTH + BYTE_OFFSET_BITS;

    // HSIZE encodings up to the bus width
    localparam logic [2:0] HSIZE_BYTE  = 3'b000;
    localparam logic [2:0] HSIZE_HALF  = 3'b001;
    localparam logic [2:0] HSIZE_WORD  = 3'b010;
    localparam logic [2:0] HSIZE_DWORD = 3'b011;

    // Data-phase owner codes used by the combiner
    localparam logic [1:0] OWNER_NONE = 2'd0;
    localparam logic [1:0] OWNER_ROM  = 2'd1;
    localparam logic [1:0] OWNER_SRAM = 2'd2;
    localparam logic [1:0] OWNER_DEF  = 2'd3;

    //////////////////////////////////////////////////
    // Enumerated codes
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    // Two-cycle ERROR response, ready low then high
    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_FIRST,
        ERR_SECOND
    } err_seq_e;

endpackage

`default_nettype wire

// ==== design/ahb_mem_subsys.sv ====
/*
 * Boot memory subsystem top level
 * One AHB-Lite manager port onto the boot ROM and the scratch SRAM,
 * with the combiner closing the ready loop internally
 */
`default_nettype none

module ahb_mem_subsys
    import ahb_mem_pkg::*;
(
    input  logic                      hclk,
    input  logic                      hreset_n,
    input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
    input  logic [AHB_DATA_WIDTH-1:0] hwdata_i,
    input  logic                      hwrite_i,
    input  logic [1:0]                htrans_i,
    input  logic [2:0]                hsize_i,
    output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
    output logic                      hreadyout_o,
    output logic                      hresp_o
);

//////////////////////////////////////////////////
// Interconnect wires
logic                      hsel_rom;
logic                      hsel_sram;
logic                      hready;
logic [AHB_DATA_WIDTH-1:0] rom_hrdata;
logic                      rom_hreadyout;
logic                      rom_hresp;
logic [AHB_DATA_WIDTH-1:0] sram_hrdata;
logic                      sram_hreadyout;
logic                      sram_hresp;
// ROM strobe path
logic                      rom_cs;
logic [ROM_ADDR_WIDTH-1:0] rom_addr;
logic [AHB_DATA_WIDTH-1:0] rom_rdata;

ahb_resp_combiner u_combiner (
    .hclk             (hclk),
    .hreset_n         (hreset_n),
    .haddr_i          (haddr_i),
    .htrans_i         (htrans_i),
    .hsel_rom_o       (hsel_rom),
    .hsel_sram_o      (hsel_sram),
    .hready_o         (hready),
    .rom_hrdata_i     (rom_hrdata),
    .rom_hreadyout_i  (rom_hreadyout),
    .rom_hresp_i      (rom_hresp),
    .sram_hrdata_i    (sram_hrdata),
    .sram_hreadyout_i (sram_hreadyout),
    .sram_hresp_i     (sram_hresp),
    .hrdata_o         (hrdata_o),
    .hreadyout_o      (hreadyout_o),
    .hresp_o          (hresp_o)
);

ahb_rom_slave u_rom_slave (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .hsel_i      (hsel_rom),
    .hready_i    (hready),
    .haddr_i     (haddr_i),
    .hwrite_i    (hwrite_i),
    .htrans_i    (htrans_i),
    .hrdata_o    (rom_hrdata),
    .hreadyout_o (rom_hreadyout),
    .hresp_o     (rom_hresp),
    .rom_cs_o    (rom_cs),
    .rom_addr_o  (rom_addr),
    .rom_rdata_i (rom_rdata)
);

boot_rom_array u_rom_array (
    .hclk    (hclk),
    .cs_i    (rom_cs),
    .addr_i  (rom_addr),
    .rdata_o (rom_rdata)
);

ahb_sram_slave u_sram_slave (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .hsel_i      (hsel_sram),
    .hready_i    (hready),
    .haddr_i     (haddr_i),
    .hwrite_i    (hwrite_i),
    .htrans_i    (htrans_i),
    .hsize_i     (hsize_i),
    .hwdata_i    (hwdata_i),
    .hrdata_o    (sram_hrdata),
    .hreadyout_o (sram_hreadyout),
    .hresp_o     (sram_hresp)
);

endmodule

`default_nettype wire

// ==== design/ahb_resp_combiner.sv ====
/*
 * AHB-Lite response combiner
 * Decodes the memory map into slave selects, tracks which slave owns
 * the data phase and muxes its read data and response back. Unmapped
 * addresses get the two-cycle ERROR from the built-in default slave
 */
`default_nettype none

module ahb_resp_combiner
    import ahb_mem_pkg::*;
(
    input  logic                      hclk,
    input  logic                      hreset_n,
    input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
    input  logic [1:0]                htrans_i,
    // Slave selects and shared ready
    output logic                      hsel_rom_o,
    output logic                      hsel_sram_o,
    output logic                      hready_o,
    // Slave responses
    input  logic [AHB_DATA_WIDTH-1:0] rom_hrdata_i,
    input  logic                      rom_hreadyout_i,
    input  logic                      rom_hresp_i,
    input  logic [AHB_DATA_WIDTH-1:0] sram_hrdata_i,
    input  logic                      sram_hreadyout_i,
    input  logic                      sram_hresp_i,
    // Combined response to the manager
    output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
    output logic                      hreadyout_o,
    output logic                      hresp_o
);

//////////////////////////////////////////////////
// Address decode
logic       rom_hit;
logic       sram_hit;
logic       xfer_valid;
logic       def_accept;
logic [1:0] owner_q;
err_seq_e   def_err_q;
logic       def_hreadyout;
logic       def_hresp;

// Compare only the bits above each region's byte offset
assign rom_hit  = (haddr_i[AHB_ADDR_WIDTH-1:ROM_BYTE_BITS] ==
                   ROM_BASE[AHB_ADDR_WIDTH-1:ROM_BYTE_BITS]);
assign sram_hit = (haddr_i[AHB_ADDR_WIDTH-1:SRAM_BYTE_BITS] ==
                   SRAM_BASE[AHB_ADDR_WIDTH-1:SRAM_BYTE_BITS]);

assign hsel_rom_o  = rom_hit;
assign hsel_sram_o = sram_hit;

// BUSY behaves like IDLE
assign xfer_valid = (htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ);
assign def_accept = hready_o && xfer_valid && !rom_hit && !sram_hit;

//////////////////////////////////////////////////
// Data-phase owner
always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
        owner_q <= OWNER_NONE;
    end else if (hready_o) begin
        if (!xfer_valid) begin
            owner_q <= OWNER_NONE;
        end else if (rom_hit) begin
            owner_q <= OWNER_ROM;
        end else if (sram_hit) begin
            owner_q <= OWNER_SRAM;
        end else begin
            owner_q <= OWNER_DEF;
        end
    end
end

// Default slave, ERROR for anything unmapped
always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
        def_err_q <= ERR_NONE;
    end else if (def_err_q == ERR_FIRST) begin
        def_err_q <= ERR_SECOND;
    end else if (def_accept) begin
        def_err_q <= ERR_FIRST;
    end else begin
        def_err_q <= ERR_NONE;
    end
end

assign def_hreadyout = (def_err_q != ERR_FIRST);
assign def_hresp     = (def_err_q != ERR_NONE) ? HRESP_ERROR : HRESP_OKAY;

//////////////////////////////////////////////////
// Response mux
always_comb begin
    hrdata_o    = '0;
    hreadyout_o = 1'b1;
    hresp_o     = HRESP_OKAY;
    case (owner_q)
        OWNER_ROM: begin
            hrdata_o    = rom_hrdata_i;
            hreadyout_o = rom_hreadyout_i;
            hresp_o     = rom_hresp_i;
        end
        OWNER_SRAM: begin
            hrdata_o    = sram_hrdata_i;
            hreadyout_o = sram_hreadyout_i;
            hresp_o     = sram_hresp_i;
        end
        OWNER_DEF: begin
            hreadyout_o = def_hreadyout;
            hresp_o     = def_hresp;
        end
        default: ;
    endcase
end

// Ready fed back to every slave
assign hready_o = hreadyout_o;

// Regions must not overlap
a_sel_onehot: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    $onehot0({hsel_rom_o, hsel_sram_o})
);

endmodule

`default_nettype wire

// ==== design/ahb_rom_slave.sv ====
/*
 * Boot ROM AHB-Lite shim
 * Turns accepted reads into ROM chip selects with a doubleword
 * index and passes the ROM data back. Writes are refused with
 * the two-cycle ERROR response
 */
`default_nettype none

module ahb_rom_slave
    import ahb_mem_pkg::*;
(
    input  logic                      hclk,
    input  logic                      hreset_n,
    // AHB-Lite slave side
    input  logic                      hsel_i,
    input  logic                      hready_i,
    input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
    input  logic                      hwrite_i,
    input  logic [1:0]                htrans_i,
    output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
    output logic                      hreadyout_o,
    output logic                      hresp_o,
    // ROM array side
    output logic                      rom_cs_o,
    output logic [ROM_ADDR_WIDTH-1:0] rom_addr_o,
    input  logic [AHB_DATA_WIDTH-1:0] rom_rdata_i
);

//////////////////////////////////////////////////
// Address phase decode
logic     xfer_accept;
logic     wr_reject;
err_seq_e err_q;
err_seq_e err_d;

// Transfer taken only on NONSEQ or SEQ with the bus ready
assign xfer_accept = hsel_i && hready_i &&
                     (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);
assign wr_reject   = xfer_accept && hwrite_i;

// Read strobe in the address phase of reads only
assign rom_cs_o   = xfer_accept && !hwrite_i;
assign rom_addr_o = haddr_i[BYTE_OFFSET_BITS +: ROM_ADDR_WIDTH];

// Array output is already aligned with the data phase
assign hrdata_o = rom_rdata_i;

//////////////////////////////////////////////////
// Error response sequence
always_comb begin
    err_d = ERR_NONE;
    case (err_q)
        ERR_FIRST: err_d = ERR_SECOND;
        // A new write may start again in the second cycle while ready is high
        default: begin
            if (wr_reject) begin
                err_d = ERR_FIRST;
            end
        end
    endcase
end

always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
        err_q <= ERR_NONE;
    end else begin
        err_q <= err_d;
    end
end

// Only the first error cycle stalls
assign hreadyout_o = (err_q != ERR_FIRST);
assign hresp_o     = (err_q != ERR_NONE) ? HRESP_ERROR : HRESP_OKAY;

//////////////////////////////////////////////////
// Checks
// No ROM strobe for a refused write nor while its ERROR stalls the bus
a_no_cs_on_write: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (wr_reject || (err_q == ERR_FIRST)) |-> !rom_cs_o
);

// ERROR on the bus lasts exactly two cycles with ready low then high
a_err_pair: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (err_q == ERR_FIRST) |-> (!hreadyout_o && (hresp_o == HRESP_ERROR))
        ##1 (hreadyout_o && (hresp_o == HRESP_ERROR))
);

endmodule

`default_nettype wire

// ==== design/ahb_sram_slave.sv ====
/*
 * Scratch SRAM AHB-Lite slave
 * 4 KiB doubleword array with byte-lane writes committed at the
 * end of the data phase, a write-to-read bypass for the word being
 * committed, and a two-cycle ERROR for sizes wider than the bus
 */
`default_nettype none

module ahb_sram_slave
    import ahb_mem_pkg::*;
(
    input  logic                      hclk,
    input  logic                      hreset_n,
    input  logic                      hsel_i,
    input  logic                      hready_i,
    input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
    input  logic                      hwrite_i,
    input  logic [1:0]                htrans_i,
    input  logic [2:0]                hsize_i,
    input  logic [AHB_DATA_WIDTH-1:0] hwdata_i,
    output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
    output logic                      hreadyout_o,
    output logic                      hresp_o
);

//////////////////////////////////////////////////
// Signals
logic [AHB_DATA_WIDTH-1:0]  mem [SRAM_DEPTH_WORDS];
logic                       xfer_accept;
logic                       size_err;
logic                       rd_accept;
logic                       wr_accept;
logic [SRAM_ADDR_WIDTH-1:0] addr_idx;
logic [BYTE_OFFSET_BITS-1:0] byte_off;
logic [BYTE_LANES-1:0]      size_mask;
logic [BYTE_LANES-1:0]      lane_mask;
logic [BYTE_OFFSET_BITS-1:0] align_mask;
// Write pending in the data phase
logic                       wr_pend_q;
logic [SRAM_ADDR_WIDTH-1:0] wr_idx_q;
logic [BYTE_LANES-1:0]      wr_mask_q;
logic [AHB_DATA_WIDTH-1:0]  rdata_q;
err_seq_e                   err_q;

//////////////////////////////////////////////////
// Address phase
assign xfer_accept = hsel_i && hready_i &&
                     (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);
assign size_err    = (hsize_i > HSIZE_DWORD);
// Oversized transfers never touch the array
assign rd_accept   = xfer_accept && !hwrite_i && !size_err;
assign wr_accept   = xfer_accept && hwrite_i && !size_err;
assign addr_idx    = haddr_i[BYTE_OFFSET_BITS +: SRAM_ADDR_WIDTH];
assign byte_off    = haddr_i[BYTE_OFFSET_BITS-1:0];

// Lanes covered by the size, and the offset bits that must be zero
always_comb begin
    size_mask  = 8'hff;
    align_mask = 3'b111;
    case (hsize_i)
        HSIZE_BYTE: begin
            size_mask  = 8'h01;
            align_mask = 3'b000;
        end
        HSIZE_HALF: begin
            size_mask  = 8'h03;
            align_mask = 3'b001;
        end
        HSIZE_WORD: begin
            size_mask  = 8'h0f;
            align_mask = 3'b011;
        end
        default: ;
    endcase
end

assign lane_mask = size_mask << byte_off;

// Capture the write for its data phase
always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
        wr_pend_q <= 1'b0;
    end else begin
        wr_pend_q <= wr_accept;
    end
end

always_ff @(posedge hclk) begin
    if (wr_accept) begin
        wr_idx_q  <= addr_idx;
        wr_mask_q <= lane_mask;
    end
end

//////////////////////////////////////////////////
// Array access
// Byte-lane commit at the end of the write data phase
always_ff @(posedge hclk) begin
    if (wr_pend_q) begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            if (wr_mask_q[b]) begin
                mem[wr_idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
            end
        end
    end
end

// Synchronous read, committing lanes forwarded on an index match
always_ff @(posedge hclk) begin
    if (rd_accept) begin
        for (int b = 0; b < BYTE_LANES; b++) begin
            if (wr_pend_q && wr_mask_q[b] && (wr_idx_q == addr_idx)) begin
                rdata_q[8*b +: 8] <= hwdata_i[8*b +: 8];
            end else begin
                rdata_q[8*b +: 8] <= mem[addr_idx][8*b +: 8];
            end
        end
    end
end

assign hrdata_o = rdata_q;

//////////////////////////////////////////////////
// Size error response
always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
        err_q <= ERR_NONE;
    end else if (err_q == ERR_FIRST) begin
        err_q <= ERR_SECOND;
    end else if (xfer_accept && size_err) begin
        err_q <= ERR_FIRST;
    end else begin
        err_q <= ERR_NONE;
    end
end

assign hreadyout_o = (err_q != ERR_FIRST);
assign hresp_o     = (err_q != ERR_NONE) ? HRESP_ERROR : HRESP_OKAY;

//////////////////////////////////////////////////
// Checks
// Data phase of a write always covers some lane
a_mask_nonempty: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    wr_accept |=> (wr_mask_q != '0)
);

a_aligned: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    (xfer_accept && !size_err) |-> ((byte_off & align_mask) == '0)
);

endmodule

`default_nettype wire

// ==== design/boot_rom_array.sv ====
/*
 * Boot ROM doubleword array
 * Synchronous read, one cycle from chip select to data,
 * contents loaded from the ROM image at time zero
 */
`default_nettype none

module boot_rom_array
    import ahb_mem_pkg::*;
(
    input  logic                      hclk,
    input  logic                      cs_i,
    input  logic [ROM_ADDR_WIDTH-1:0] addr_i,
    output logic [AHB_DATA_WIDTH-1:0] rdata_o
);

// Constant image contents
logic [AHB_DATA_WIDTH-1:0] mem [ROM_DEPTH_WORDS];

initial begin
    $readmemh("boot_rom.hex", mem);
end

// Output holds its value while the strobe is low
always_ff @(posedge hclk) begin
    if (cs_i) begin
        rdata_o <= mem[addr_i];
    end
end

endmodule

`default_nettype wire

// ==== dv/tb_ahb_mem_subsys.sv ====
/*
 * Testbench for the boot memory subsystem
 * Applies a table of AHB-Lite transfers in order and checks each
 * response against a ROM image model and a byte-lane SRAM model
 */
`default_nettype none

module tb_ahb_mem_subsys
    import ahb_mem_pkg::*;
();

localparam int MAX_ENTRIES   = 40;
localparam int READY_TIMEOUT = 16;

//////////////////////////////////////////////////
// DUT signals
logic                      hclk;
logic                      hreset_n;
logic [AHB_ADDR_WIDTH-1:0] haddr;
logic [AHB_DATA_WIDTH-1:0] hwdata;
logic                      hwrite;
logic [1:0]                htrans;
logic [2:0]                hsize;
logic [AHB_DATA_WIDTH-1:0] hrdata;
logic                      hreadyout;
logic                      hresp;

// Transfer table, one column per field
logic                      tbl_write [MAX_ENTRIES];
logic [AHB_ADDR_WIDTH-1:0] tbl_addr  [MAX_ENTRIES];
logic [2:0]                tbl_size  [MAX_ENTRIES];
logic [AHB_DATA_WIDTH-1:0] tbl_wdata [MAX_ENTRIES];
logic                      tbl_b2b   [MAX_ENTRIES];
logic                      tbl_err   [MAX_ENTRIES];
int                        num_entries;

// Reference memories
logic [AHB_DATA_WIDTH-1:0] rom_model  [ROM_DEPTH_WORDS];
logic [AHB_DATA_WIDTH-1:0] sram_model [SRAM_DEPTH_WORDS];

int errors;
int failed_entries;
bit aborted;

initial begin
    hclk = 1'b0;
end

always #20 hclk = ~hclk;

ahb_mem_subsys dut_i (
    .hclk        (hclk),
    .hreset_n    (hreset_n),
    .haddr_i     (haddr),
    .hwdata_i    (hwdata),
    .hwrite_i    (hwrite),
    .htrans_i    (htrans),
    .hsize_i     (hsize),
    .hrdata_o    (hrdata),
    .hreadyout_o (hreadyout),
    .hresp_o     (hresp)
);

//////////////////////////////////////////////////
// Memory map and lane helpers
function automatic bit in_rom(input logic [AHB_ADDR_WIDTH-1:0] addr);
    return (addr - ROM_BASE) < 32'(ROM_DEPTH_WORDS * 8);
endfunction

function automatic bit in_sram(input logic [AHB_ADDR_WIDTH-1:0] addr);
    return (addr - SRAM_BASE) < 32'(SRAM_DEPTH_WORDS * 8);
endfunction

function automatic int dword_index(input logic [AHB_ADDR_WIDTH-1:0] addr,
                                   input logic [AHB_ADDR_WIDTH-1:0] base);
    return int'((addr - base) >> BYTE_OFFSET_BITS);
endfunction

// 2**hsize bytes, starting at the byte offset
function automatic logic [BYTE_LANES-1:0] size_lanes(input logic [2:0] size,
                                                     input logic [2:0] off);
    int nbytes;
    nbytes = 1 << size;
    return BYTE_LANES'(((1 << nbytes) - 1) << off);
endfunction

function automatic logic [AHB_DATA_WIDTH-1:0] merge_lanes(
    input logic [AHB_DATA_WIDTH-1:0] old_word,
    input logic [AHB_DATA_WIDTH-1:0] new_word,
    input logic [BYTE_LANES-1:0]     lanes
);
    logic [AHB_DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < BYTE_LANES; b++) begin
        if (lanes[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
        end
    end
    return result;
endfunction

//////////////////////////////////////////////////
// Checks
task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
        $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_word(input string name, input logic [AHB_DATA_WIDTH-1:0] exp,
                          input logic [AHB_DATA_WIDTH-1:0] act);
    assert (act === exp) else begin
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    assert (act == exp) else begin
        $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
        errors++;
    end
endtask

//////////////////////////////////////////////////
// Table construction
task automatic add_entry(input logic wr, input logic [AHB_ADDR_WIDTH-1:0] addr,
                         input logic [2:0] size, input logic b2b, input logic err);
    tbl_write[num_entries] = wr;
    tbl_addr[num_entries]  = addr;
    tbl_size[num_entries]  = size;
    tbl_wdata[num_entries] = '0;
    tbl_b2b[num_entries]   = b2b;
    tbl_err[num_entries]   = err;
    num_entries++;
endtask

task automatic build_table();
    // ROM reads, the last two overlapping the previous data phase
    add_entry(1'b0, 32'h0000_0000, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b0, 32'h0000_0008, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b0, 32'h0000_0080, HSIZE_DWORD, 1'b1, 1'b0);
    add_entry(1'b0, 32'h0000_00f8, HSIZE_DWORD, 1'b1, 1'b0);
    // ROM writes refused, image unchanged
    add_entry(1'b1, 32'h0000_0040, HSIZE_DWORD, 1'b0, 1'b1);
    add_entry(1'b0, 32'h0000_0040, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b1, 32'h0000_0048, HSIZE_DWORD, 1'b0, 1'b1);
    // Offered during the first ERROR cycle and held
    add_entry(1'b0, 32'h0000_0048, HSIZE_DWORD, 1'b1, 1'b0);
    // SRAM fill with full doublewords
    add_entry(1'b1, 32'h1000_0000, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b1, 32'h1000_0008, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b1, 32'h1000_0010, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b1, 32'h1000_0ff8, HSIZE_DWORD, 1'b0, 1'b0);
    // Narrow writes then readback
    add_entry(1'b1, 32'h1000_0003, HSIZE_BYTE,  1'b0, 1'b0);
    add_entry(1'b1, 32'h1000_000a, HSIZE_HALF,  1'b0, 1'b0);
    add_entry(1'b1, 32'h1000_0014, HSIZE_WORD,  1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0000, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0008, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0010, HSIZE_DWORD, 1'b0, 1'b0);
    // Write then read of the same doubleword through the bypass
    add_entry(1'b1, 32'h1000_0005, HSIZE_BYTE,  1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0000, HSIZE_DWORD, 1'b1, 1'b0);
    add_entry(1'b1, 32'h1000_000c, HSIZE_WORD,  1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0008, HSIZE_DWORD, 1'b1, 1'b0);
    add_entry(1'b1, 32'h1000_0ff8, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0ff8, HSIZE_DWORD, 1'b1, 1'b0);
    // Oversized transfers
    add_entry(1'b1, 32'h1000_0010, 3'd4,        1'b0, 1'b1);
    add_entry(1'b0, 32'h1000_0010, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b0, 32'h1000_0ff8, 3'd5,        1'b0, 1'b1);
    // Unmapped space, default slave
    add_entry(1'b0, 32'h2000_0000, HSIZE_DWORD, 1'b0, 1'b1);
    add_entry(1'b0, 32'h0000_0010, HSIZE_DWORD, 1'b0, 1'b0);
    add_entry(1'b1, 32'h0000_0100, HSIZE_DWORD, 1'b0, 1'b1);
    add_entry(1'b0, 32'h1000_0000, HSIZE_DWORD, 1'b1, 1'b0);
endtask

task automatic fill_write_data();
    for (int i = 0; i < num_entries; i++) begin
        if (tbl_write[i] && in_sram(tbl_addr[i])) begin
            tbl_wdata[i] = {$urandom, $urandom};
        end
    end
endtask

//////////////////////////////////////////////////
// Bus driving
task automatic drive_addr_phase(input int idx);
    haddr  <= tbl_addr[idx];
    hwrite <= tbl_write[idx];
    hsize  <= tbl_size[idx];
    htrans <= HTRANS_NONSEQ;
endtask

// Sample at the falling edge until the data phase completes
task automatic wait_data_phase(input logic exp_err, output int stalls,
                               output bit timed_out);
    bit done;
    stalls    = 0;
    timed_out = 1'b0;
    done      = 1'b0;
    while (!done && !timed_out) begin
        @(negedge hclk);
        if (hreadyout === 1'b1) begin
            done = 1'b1;
        end else begin
            // First ERROR cycle already carries the response
            if (stalls == 0 && exp_err) begin
                check_bit("hresp_o", HRESP_ERROR, hresp);
            end
            stalls++;
            if (stalls > READY_TIMEOUT) begin
                timed_out = 1'b1;
            end else begin
                @(posedge hclk);
            end
        end
    end
endtask

//////////////////////////////////////////////////
// Main sequence
initial begin
    int                        stalls;
    bit                        timed_out;
    bit                        issued;
    bit                        next_issued;
    int                        errors_before;
    logic [AHB_DATA_WIDTH-1:0] exp_data;
    logic [BYTE_LANES-1:0]     lanes;
    int                        idx;

    hreset_n       = 1'b0;
    haddr          = '0;
    hwdata         = '0;
    hwrite         = 1'b0;
    htrans         = HTRANS_IDLE;
    hsize          = HSIZE_DWORD;
    errors         = 0;
    failed_entries = 0;
    num_entries    = 0;
    aborted        = 1'b0;
    issued         = 1'b0;
    void'($urandom(32'heab));
    $readmemh("boot_rom.hex", rom_model);
    build_table();
    fill_write_data();

    repeat (8) @(posedge hclk);
    hreset_n <= 1'b1;

    for (int i = 0; i < num_entries && !aborted; i++) begin
        errors_before = errors;
        if (!issued) begin
            @(posedge hclk);
            drive_addr_phase(i);
        end
        // Address sampled here, data phase starts
        @(posedge hclk);
        hwdata      <= tbl_wdata[i];
        next_issued = (i + 1 < num_entries) && tbl_b2b[i + 1];
        if (next_issued) begin
            drive_addr_phase(i + 1);
        end else begin
            htrans <= HTRANS_IDLE;
        end
        wait_data_phase(tbl_err[i], stalls, timed_out);

        if (timed_out) begin
            $display("timeout: entry %0d never saw hreadyout_o high", i);
            errors++;
            aborted = 1'b1;
        end else begin
            check_count("hreadyout_o low cycles", tbl_err[i] ? 1 : 0, stalls);
            check_bit("hresp_o", tbl_err[i] ? HRESP_ERROR : HRESP_OKAY, hresp);
            if (!tbl_err[i] && tbl_write[i] && in_sram(tbl_addr[i])) begin
                // Model commit, same order as the bus
                idx   = dword_index(tbl_addr[i], SRAM_BASE);
                lanes = size_lanes(tbl_size[i], tbl_addr[i][2:0]);
                sram_model[idx] = merge_lanes(sram_model[idx], tbl_wdata[i], lanes);
            end else if (!tbl_err[i] && !tbl_write[i]) begin
                if (in_rom(tbl_addr[i])) begin
                    exp_data = rom_model[dword_index(tbl_addr[i], ROM_BASE)];
                end else begin
                    exp_data = sram_model[dword_index(tbl_addr[i], SRAM_BASE)];
                end
                check_word("hrdata_o", exp_data, hrdata);
            end
        end

        if (errors != errors_before) begin
            failed_entries++;
        end
        $display("entry %0d %s addr %h size %0d: %s", i,
                 tbl_write[i] ? "write" : "read", tbl_addr[i], tbl_size[i],
                 (errors == errors_before) ? "ok" : "failed");
        issued = next_issued;
    end

    $display("entries %0d, failed %0d, errors %0d", num_entries, failed_entries, errors);
    if (errors == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== tb.f ====
design/ahb_mem_pkg.sv
design/ahb_rom_slave.sv
design/boot_rom_array.sv
design/ahb_sram_slave.sv
design/ahb_resp_combiner.sv
design/ahb_mem_subsys.sv
dv/tb_ahb_mem_subsys.sv
